/* logic/ssa_pkg.sv */
`default_nettype none

package ssa_pkg;

    // router geometry
    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 2;
    localparam int PORT_W    = 3;
    localparam int PAYLOAD_W = 32;

    // port numbering of a 2D mesh router
    localparam int PORT_LOCAL = 0;
    localparam int PORT_EAST  = 1;
    localparam int PORT_NORTH = 2;
    localparam int PORT_WEST  = 3;
    localparam int PORT_SOUTH = 4;

    typedef logic [PORT_W-1:0]    port_idx_t;
    typedef logic [NUM_VCS-1:0]   vc_mask_t;
    typedef logic [NUM_PORTS-1:0] port_mask_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // dest_port only valid in header flits
    typedef struct packed {
        logic      hdr_flg;
        logic      tail_flg;
        vc_mask_t  vc;
        port_idx_t dest_port;
        payload_t  payload;
    } flit_t;

    typedef struct packed {
        logic      ivc_req;
        logic      ovc_is_assigned;
        vc_mask_t  assigned_ovc;
        port_idx_t dest_port;
    } ivc_info_t;

    typedef struct packed {
        vc_mask_t avail;
        vc_mask_t full;
    } ovc_status_t;

    typedef struct packed {
        vc_mask_t  vc_wr;
        logic      hdr_flg;
        logic      tail_flg;
        port_idx_t dest_port;
    } flit_fields_t;

    typedef struct packed {
        logic ivc_reset;
        logic credit_dec;
        logic sw_grant;
        logic ovc_grant;
        logic ovc_alloc;
        logic ovc_release;
    } vc_grant_t;

    typedef struct packed {
        vc_mask_t ovc_is_allocated;
        vc_mask_t ovc_is_released;
        vc_mask_t ivc_num_getting_sw_grant;
        vc_mask_t ivc_num_getting_ovc_grant;
        vc_mask_t ivc_reset;
        vc_mask_t buff_space_decreased;
        vc_mask_t ivc_single_flit_pck;
        vc_mask_t ovc_single_flit_pck;
        vc_mask_t ivc_granted_ovc_num;
        logic     ssa_flit_wr;
    } ssa_ctrl_t;

    // east <-> west, north <-> south, local has no partner
    function automatic port_idx_t straight_port(input port_idx_t p);
        case (p)
            port_idx_t'(PORT_EAST):  return port_idx_t'(PORT_WEST);
            port_idx_t'(PORT_NORTH): return port_idx_t'(PORT_SOUTH);
            port_idx_t'(PORT_WEST):  return port_idx_t'(PORT_EAST);
            port_idx_t'(PORT_SOUTH): return port_idx_t'(PORT_NORTH);
            default:                 return port_idx_t'(PORT_LOCAL);
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/ssa_flit_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_flit_decode
    import ssa_pkg::*;
(
    input  wire logic   flit_wr_i,
    input  wire flit_t  flit_i,
    output flit_fields_t fields_o
);

    vc_mask_t vc_wr;

    // a VC sees a write only while the port strobe is up
    assign vc_wr = flit_i.vc & {NUM_VCS{flit_wr_i}};

    // header and tail flags pass through untouched,
    // the decider qualifies them with its own VC bit
    assign fields_o.vc_wr     = vc_wr;
    assign fields_o.hdr_flg   = flit_i.hdr_flg;
    assign fields_o.tail_flg  = flit_i.tail_flg;

    // dest port is garbage on body and tail flits
    assign fields_o.dest_port = flit_i.dest_port;

    // upstream VC selection must put each flit in exactly one VC,
    // otherwise two deciders would both claim the same flit
    always_comb begin
        if (flit_wr_i) begin
            assert ($onehot(flit_i.vc))
            else $error("ssa_flit_decode: written flit vc 0x%0h is not one-hot",
                        flit_i.vc);
        end
    end

endmodule

`default_nettype wire

/* logic/ssa_vc_decision.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_vc_decision
    import ssa_pkg::*;
#(
    parameter int IN_PORT = PORT_EAST,
    parameter int VC      = 0
) (
    input  wire logic         clk,
    input  wire flit_fields_t fields_i,
    input  wire ivc_info_t    ivc_info_i,
    input  wire ovc_status_t  ss_ovc_status_i,
    input  wire logic         ss_ovc_granted_i,
    input  wire logic         in_sw_granted_i,
    output vc_grant_t         grant_o,
    output logic              single_flit_o
);

    localparam port_idx_t SS_PORT = straight_port(port_idx_t'(IN_PORT));

    // only non-local inputs own a straight path
    if (SS_PORT == port_idx_t'(PORT_LOCAL)) begin : g_bad_port
        $error("ssa_vc_decision: port %0d has no straight partner", IN_PORT);
    end
    if (VC >= NUM_VCS) begin : g_bad_vc
        $error("ssa_vc_decision: VC %0d out of range", VC);
    end

    logic vc_wr;
    logic hdr_to_ss;
    logic single;
    logic assigned_ready;
    logic ovc_ready;
    logic permit;
    logic go;
    logic credit_pre;
    logic alloc_pre;
    logic release_pre;

    assign vc_wr     = fields_i.vc_wr[VC];
    assign hdr_to_ss = (fields_i.dest_port == SS_PORT);
    assign single    = fields_i.hdr_flg & fields_i.tail_flg;

    // packet already owns an output VC: it must be ours at the ss port
    // and still have room
    assign assigned_ready = (ivc_info_i.dest_port == SS_PORT)
                          & ivc_info_i.assigned_ovc[VC]
                          & ~ss_ovc_status_i.full[VC];

    // new packet needs a free VC with the same number at the ss port
    assign ovc_ready = ivc_info_i.ovc_is_assigned ? assigned_ready
                                                  : ss_ovc_status_i.avail[VC];

    // normal allocation always wins over the straight path
    assign permit = ovc_ready
                  & ~ivc_info_i.ivc_req
                  & ~ss_ovc_granted_i
                  & ~in_sw_granted_i;

    assign go = vc_wr & permit;

    // header heading elsewhere takes the normal path
    assign credit_pre  = ~(fields_i.hdr_flg & ~hdr_to_ss);
    assign alloc_pre   = fields_i.hdr_flg & hdr_to_ss;
    assign release_pre = single ? credit_pre : fields_i.tail_flg;

    assign grant_o.ivc_reset   = release_pre & go;
    assign grant_o.credit_dec  = credit_pre & go;
    assign grant_o.sw_grant    = credit_pre & go;
    assign grant_o.ovc_grant   = alloc_pre & go;

    // single-flit packets never hold the output VC past this cycle
    assign grant_o.ovc_alloc   = alloc_pre & go & ~single;
    assign grant_o.ovc_release = release_pre & go & ~single;

    assign single_flit_o = single & vc_wr;

    // a grant must be backed by a flit in this VC
    a_grant_needs_write: assert property (
        @(posedge clk) (|grant_o) |-> fields_i.vc_wr[VC]
    ) else $error("ssa_vc_decision p%0d v%0d: grant without write", IN_PORT, VC);

    // the output VC bookkeeping is skipped for single-flit packets
    a_single_no_ovc: assert property (
        @(posedge clk) single_flit_o |-> !(grant_o.ovc_alloc || grant_o.ovc_release)
    ) else $error("ssa_vc_decision p%0d v%0d: single flit touched ovc", IN_PORT, VC);

endmodule

`default_nettype wire

/* logic/ssa_ctrl_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_ctrl_merge
    import ssa_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_i,
    input  wire vc_grant_t vc_grant_i [NUM_PORTS][NUM_VCS],
    input  wire vc_mask_t  single_flit_i [NUM_PORTS],
    output ssa_ctrl_t      ssa_ctrl_o [NUM_PORTS]
);

    port_mask_t ss_sw_any;
    port_mask_t ssa_flit_wr_q;

    for (genvar q = 0; q < NUM_PORTS; q++) begin : g_port
        // input port whose straight path ends at output q
        localparam port_idx_t SRC    = straight_port(port_idx_t'(q));
        localparam bit        HAS_SS = (SRC != port_idx_t'(q));

        vc_mask_t own_reset, own_sw, own_ovc, own_num;
        vc_mask_t ss_alloc, ss_release, ss_credit, ss_sw, ss_single;

        always_comb begin
            own_reset  = '0;
            own_sw     = '0;
            own_ovc    = '0;
            own_num    = '0;
            ss_alloc   = '0;
            ss_release = '0;
            ss_credit  = '0;
            ss_sw      = '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                own_reset[v] = vc_grant_i[q][v].ivc_reset;
                own_sw[v]    = vc_grant_i[q][v].sw_grant;
                own_ovc[v]   = vc_grant_i[q][v].ovc_grant;
                // straight path keeps the VC number across the router
                if (vc_grant_i[q][v].ovc_grant) begin
                    own_num = own_num | (vc_mask_t'(1) << v);
                end
                if (HAS_SS) begin
                    ss_alloc[v]   = vc_grant_i[SRC][v].ovc_alloc;
                    ss_release[v] = vc_grant_i[SRC][v].ovc_release;
                    ss_credit[v]  = vc_grant_i[SRC][v].credit_dec;
                    ss_sw[v]      = vc_grant_i[SRC][v].sw_grant;
                end
            end
        end

        assign ss_single    = HAS_SS ? single_flit_i[SRC] : '0;
        assign ss_sw_any[q] = |ss_sw;

        assign ssa_ctrl_o[q] = '{
            ovc_is_allocated:          ss_alloc,
            ovc_is_released:           ss_release,
            ivc_num_getting_sw_grant:  own_sw,
            ivc_num_getting_ovc_grant: own_ovc,
            ivc_reset:                 own_reset,
            buff_space_decreased:      ss_credit,
            ivc_single_flit_pck:       single_flit_i[q],
            ovc_single_flit_pck:       ss_single,
            ivc_granted_ovc_num:       own_num,
            ssa_flit_wr:               ssa_flit_wr_q[q]
        };

        // one output VC cannot be taken and freed by the same flit
        a_alloc_release_excl: assert property (
            @(posedge clk) disable iff (rst_i) !(|(ss_alloc & ss_release))
        ) else $error("ssa_ctrl_merge: port %0d alloc and release overlap", q);
    end

    // flit reaches the ss output buffer one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ssa_flit_wr_q <= '0;
        end else begin
            ssa_flit_wr_q <= ss_sw_any;
        end
    end

endmodule

`default_nettype wire

/* logic/ss_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

module ss_allocator
    import ssa_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire port_mask_t  flit_wr_i,
    input  wire flit_t       flit_i [NUM_PORTS],
    input  wire ivc_info_t   ivc_info_i [NUM_PORTS][NUM_VCS],
    input  wire ovc_status_t ovc_status_i [NUM_PORTS],
    input  wire port_mask_t  any_ovc_granted_i,
    input  wire port_mask_t  any_ivc_sw_granted_i,
    output ssa_ctrl_t        ssa_ctrl_o [NUM_PORTS]
);

    flit_fields_t fields [NUM_PORTS];
    vc_grant_t    vc_grant [NUM_PORTS][NUM_VCS];
    vc_mask_t     single_flit [NUM_PORTS];

    // input side, one decoder per port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_dec
        ssa_flit_decode u_decode (
            .flit_wr_i (flit_wr_i[p]),
            .flit_i    (flit_i[p]),
            .fields_o  (fields[p])
        );
    end

    // one decider per non-local input VC
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        localparam port_idx_t SS = straight_port(port_idx_t'(p));

        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            if (p == PORT_LOCAL) begin : g_none
                // local port never takes the straight path
                assign vc_grant[p][v]    = '0;
                assign single_flit[p][v] = 1'b0;
            end else begin : g_ssa
                ssa_vc_decision #(
                    .IN_PORT (p),
                    .VC      (v)
                ) u_decision (
                    .clk              (clk),
                    .fields_i         (fields[p]),
                    .ivc_info_i       (ivc_info_i[p][v]),
                    .ss_ovc_status_i  (ovc_status_i[SS]),
                    .ss_ovc_granted_i (any_ovc_granted_i[SS]),
                    .in_sw_granted_i  (any_ivc_sw_granted_i[p]),
                    .grant_o          (vc_grant[p][v]),
                    .single_flit_o    (single_flit[p][v])
                );
            end
        end
    end

    // output side, per-port records and the delayed write strobe
    ssa_ctrl_merge u_merge (
        .clk           (clk),
        .rst_i         (rst_i),
        .vc_grant_i    (vc_grant),
        .single_flit_i (single_flit),
        .ssa_ctrl_o    (ssa_ctrl_o)
    );

endmodule

`default_nettype wire

/* sim/ss_allocator_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ss_allocator_tb
    import ssa_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_CYCLES = 2000;
    localparam int TIMEOUT_NS    = (RANDOM_CYCLES + 100) * CLK_PERIOD;

    logic        clk;
    logic        rst_i;
    port_mask_t  flit_wr;
    flit_t       flit [NUM_PORTS];
    ivc_info_t   ivc_info [NUM_PORTS][NUM_VCS];
    ovc_status_t ovc_status [NUM_PORTS];
    port_mask_t  any_ovc_granted;
    port_mask_t  any_ivc_sw_granted;
    ssa_ctrl_t   ssa_ctrl [NUM_PORTS];

    // reference model state
    ssa_ctrl_t   exp_ctrl [NUM_PORTS];
    port_mask_t  exp_sw_any;
    port_mask_t  exp_wr_q;

    logic        check_en;
    int          errors = 0;
    int          cycles = 0;

    ss_allocator ss_allocator_inst (
        .clk                  (clk),
        .rst_i                (rst_i),
        .flit_wr_i            (flit_wr),
        .flit_i               (flit),
        .ivc_info_i           (ivc_info),
        .ovc_status_i         (ovc_status),
        .any_ovc_granted_i    (any_ovc_granted),
        .any_ivc_sw_granted_i (any_ivc_sw_granted),
        .ssa_ctrl_o           (ssa_ctrl)
    );

    // east pairs with west and north with south
    function automatic int partner_of(input int p);
        case (p)
            1:       return 3;
            2:       return 4;
            3:       return 1;
            4:       return 2;
            default: return 0;
        endcase
    endfunction

    // expected records for the current inputs
    always_comb begin
        int   s;
        logic wr;
        logic single;
        logic ready;
        logic go;
        logic credit;
        logic alloc;
        logic rel;
        exp_sw_any = '0;
        for (int q = 0; q < NUM_PORTS; q++) begin
            exp_ctrl[q] = '0;
        end
        for (int p = 1; p < NUM_PORTS; p++) begin
            s = partner_of(p);
            for (int v = 0; v < NUM_VCS; v++) begin
                wr     = flit_wr[p] && flit[p].vc[v];
                single = flit[p].hdr_flg && flit[p].tail_flg;
                if (ivc_info[p][v].ovc_is_assigned) begin
                    ready = (int'(ivc_info[p][v].dest_port) == s)
                         && ivc_info[p][v].assigned_ovc[v] && !ovc_status[s].full[v];
                end else begin
                    ready = ovc_status[s].avail[v];
                end
                go = wr && ready && !ivc_info[p][v].ivc_req
                  && !any_ovc_granted[s] && !any_ivc_sw_granted[p];
                credit = !(flit[p].hdr_flg && int'(flit[p].dest_port) != s);
                alloc  = flit[p].hdr_flg && int'(flit[p].dest_port) == s;
                rel    = single ? credit : flit[p].tail_flg;
                if (go) begin
                    exp_ctrl[p].ivc_reset[v]                 = rel;
                    exp_ctrl[p].ivc_num_getting_sw_grant[v]  = credit;
                    exp_ctrl[p].ivc_num_getting_ovc_grant[v] = alloc;
                    exp_ctrl[p].ivc_granted_ovc_num[v]       = alloc;
                    exp_ctrl[s].buff_space_decreased[v]      = credit;
                    exp_ctrl[s].ovc_is_allocated[v]          = alloc && !single;
                    exp_ctrl[s].ovc_is_released[v]           = rel && !single;
                    if (credit) begin
                        exp_sw_any[s] = 1'b1;
                    end
                end
                exp_ctrl[p].ivc_single_flit_pck[v] = wr && single;
                exp_ctrl[s].ovc_single_flit_pck[v] = wr && single;
            end
        end
        for (int q = 0; q < NUM_PORTS; q++) begin
            exp_ctrl[q].ssa_flit_wr = exp_wr_q[q];
        end
    end

    // flit write at the straight output lags the sw grant by one clock
    always_ff @(posedge clk) begin
        if (rst_i) begin
            exp_wr_q <= '0;
        end else begin
            exp_wr_q <= exp_sw_any;
        end
    end

    task automatic compare_field(input string name, input int port,
                                 input logic [1:0] exp_val, input logic [1:0] got_val);
        if (exp_val !== got_val) begin
            errors++;
            $display("error at %0d ns: ssa_ctrl_o[%0d].%s expected %0h got %0h",
                     $time, port, name, exp_val, got_val);
        end
    endtask

    task automatic report_record(input int port, input ssa_ctrl_t e, input ssa_ctrl_t g);
        compare_field("ovc_is_allocated", port, e.ovc_is_allocated, g.ovc_is_allocated);
        compare_field("ovc_is_released", port, e.ovc_is_released, g.ovc_is_released);
        compare_field("ivc_num_getting_sw_grant", port,
                      e.ivc_num_getting_sw_grant, g.ivc_num_getting_sw_grant);
        compare_field("ivc_num_getting_ovc_grant", port,
                      e.ivc_num_getting_ovc_grant, g.ivc_num_getting_ovc_grant);
        compare_field("ivc_reset", port, e.ivc_reset, g.ivc_reset);
        compare_field("buff_space_decreased", port,
                      e.buff_space_decreased, g.buff_space_decreased);
        compare_field("ivc_single_flit_pck", port,
                      e.ivc_single_flit_pck, g.ivc_single_flit_pck);
        compare_field("ovc_single_flit_pck", port,
                      e.ovc_single_flit_pck, g.ovc_single_flit_pck);
        compare_field("ivc_granted_ovc_num", port,
                      e.ivc_granted_ovc_num, g.ivc_granted_ovc_num);
        compare_field("ssa_flit_wr", port, {1'b0, e.ssa_flit_wr}, {1'b0, g.ssa_flit_wr});
    endtask

    for (genvar q = 0; q < NUM_PORTS; q++) begin : g_chk
        a_record: assert property (@(posedge clk) disable iff (!check_en)
            ssa_ctrl[q] === exp_ctrl[q])
            else report_record(q, $sampled(exp_ctrl[q]), $sampled(ssa_ctrl[q]));
    end

    task automatic clear_inputs();
        flit_wr            <= '0;
        any_ovc_granted    <= '0;
        any_ivc_sw_granted <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            flit[p]       <= '0;
            ovc_status[p] <= '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                ivc_info[p][v] <= '0;
            end
        end
    endtask

    // straight headers on every non-local port in vc 0
    task automatic drive_straight_headers();
        int s;
        for (int p = PORT_EAST; p < NUM_PORTS; p++) begin
            s = partner_of(p);
            flit_wr[p] <= 1'b1;
            flit[p] <= '{hdr_flg: 1'b1, tail_flg: 1'b0, vc: vc_mask_t'(1),
                         dest_port: port_idx_t'(s),
                         payload: payload_t'($urandom())};
            ovc_status[s] <= '{avail: '1, full: '0};
        end
    endtask

    // one flit on port p and vc v followed by an idle cycle
    // to_ss selects the straight port as header destination instead of local
    task automatic try_flit(input int p, input int v, input bit hdr, input bit tail,
                            input bit to_ss, input bit assigned, input bit req,
                            input bit avail, input bit full, input bit ovc_g,
                            input bit sw_g);
        int       s;
        vc_mask_t onehot;
        s      = partner_of(p);
        onehot = vc_mask_t'(1 << v);
        @(posedge clk);
        clear_inputs();
        flit_wr[p] <= 1'b1;
        flit[p] <= '{hdr_flg: hdr, tail_flg: tail, vc: onehot,
                     dest_port: port_idx_t'(to_ss ? s : PORT_LOCAL),
                     payload: payload_t'($urandom())};
        ivc_info[p][v] <= '{ivc_req: req, ovc_is_assigned: assigned,
                            assigned_ovc: onehot, dest_port: port_idx_t'(s)};
        ovc_status[s] <= '{avail: avail ? onehot : '0, full: full ? onehot : '0};
        any_ovc_granted[s]    <= ovc_g;
        any_ivc_sw_granted[p] <= sw_g;
        @(posedge clk);
        clear_inputs();
    endtask

    // straight port half of the time
    function automatic port_idx_t pick_dest(input int s);
        if ($urandom_range(0, 1) == 1) begin
            return port_idx_t'(s);
        end
        return port_idx_t'($urandom_range(0, NUM_PORTS - 1));
    endfunction

    task automatic drive_random();
        int s;
        flit_wr            <= port_mask_t'($urandom());
        any_ovc_granted    <= port_mask_t'($urandom() & $urandom() & $urandom());
        any_ivc_sw_granted <= port_mask_t'($urandom() & $urandom() & $urandom());
        for (int p = 0; p < NUM_PORTS; p++) begin
            s = partner_of(p);
            flit[p] <= '{hdr_flg: ($urandom_range(0, 1) == 1),
                         tail_flg: ($urandom_range(0, 1) == 1),
                         vc: vc_mask_t'(1 << $urandom_range(0, NUM_VCS - 1)),
                         dest_port: pick_dest(s),
                         payload: payload_t'($urandom())};
            ovc_status[p] <= '{avail: vc_mask_t'($urandom()),
                               full: vc_mask_t'($urandom() & $urandom())};
            for (int v = 0; v < NUM_VCS; v++) begin
                ivc_info[p][v] <= '{ivc_req: ($urandom_range(0, 3) == 0),
                                    ovc_is_assigned: ($urandom_range(0, 1) == 1),
                                    assigned_ovc: vc_mask_t'($urandom()),
                                    dest_port: pick_dest(s)};
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (check_en) begin
            cycles <= cycles + 1;
        end
    end

    // hang guard
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h26fbaa10));
        rst_i    = 1'b1;
        check_en = 1'b0;
        clear_inputs();
        @(posedge clk);
        check_en <= 1'b1;
        // grants during reset must not reach ssa_flit_wr
        drive_straight_headers();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        clear_inputs();
        repeat (3) @(posedge clk);

        // argument order is p v hdr tail to_ss assigned req avail full ovc_g sw_g
        for (int p = PORT_EAST; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                try_flit(p, v, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
            end
        end

        // each blocking condition alone
        try_flit(2, 1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        try_flit(2, 1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        try_flit(2, 1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        try_flit(2, 1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

        // header turning away from the straight port
        try_flit(1, 0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);

        // body and tail on an assigned ovc and again with that ovc full
        try_flit(3, 0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        try_flit(3, 0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        try_flit(3, 0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        try_flit(3, 0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        // single-flit packets
        try_flit(4, 1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        try_flit(4, 0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            drive_random();
        end

        // drain the delayed write strobe
        @(posedge clk);
        clear_inputs();
        repeat (2) @(posedge clk);
        #1;
        $display("checked %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/ssa_pkg.sv
logic/ssa_flit_decode.sv
logic/ssa_vc_decision.sv
logic/ssa_ctrl_merge.sv
logic/ss_allocator.sv
sim/ss_allocator_tb.sv

/* Makefile */
TOP = ss_allocator_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f all.f --top-module ss_allocator

clean:
	rm -rf obj_dir
